//--- vlog.f
hw/lsu_pkg.sv
hw/load_store_unit.sv
hw/clint_timer.sv
hw/mem_router.sv
hw/mem_subsys_top.sv
verification/ext_mem_model.sv
verification/mem_subsys_sva.sv
verification/tb_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --timing -Wno-fatal --top-module tb_top -f vlog.f -o sim_tb \
    && ./obj_dir/sim_tb +verilator+error+limit+1000 \
    || exit 1

//--- verification/tb_top.sv
`default_nettype none

module tb_top;
    timeunit 1ns;
    timeprecision 1ps;
    import lsu_pkg::*;

    localparam addr_t clint_base = 64'h0000_0000_0200_0000;
    localparam int    wait_limit = 200;

    logic      inst_selfdefine;
    logic      reset;
    logic      core_req_valid;
    logic      core_req_ready;
    core_req_t core_req;
    logic      core_rsp_valid;
    logic      core_rsp_ready;
    core_rsp_t core_rsp;
    logic      ext_valid;
    logic      ext_ready;
    bus_req_t  ext_req;
    bus_rsp_t  ext_rsp;
    logic      mtip;
    integer    seed;
    xlen_t     rd;
    xlen_t     t0;
    int        polls;

    mem_subsys_top #(.clint_base(clint_base), .mtime_div(1)) u_dut (.*);

    ext_mem_model u_ext (
        .inst_selfdefine (inst_selfdefine),
        .reset           (reset),
        .ext_valid       (ext_valid),
        .ext_ready       (ext_ready),
        .ext_req         (ext_req),
        .ext_rsp         (ext_rsp)
    );

    initial begin
        inst_selfdefine = 1'b0;
        forever #5 inst_selfdefine = ~inst_selfdefine;
    end

    task automatic abort_run(input string why);
        $display("Some tests failed");
        $fatal(1, "%s", why);
    endtask

    // first failing assertion ends the run
    always @(negedge inst_selfdefine) begin
        if (u_dut.u_sva.fail_cnt != 0) begin
            abort_run("assertion failed");
        end
    end

    function automatic addr_t rand_addr(input int align);
        addr_t a;
        a = {32'h8000_0000 | 32'($random(seed)), 32'($random(seed))};
        return a & ~((64'd1 << align) - 64'd1);
    endfunction

    // one full access; hold keeps the response waiting that many cycles
    task automatic do_access(input ls_op_e op, input addr_t addr, input xlen_t wdata,
                             input int hold, output xlen_t rdata);
        int n;
        core_req.op    = op;
        core_req.addr  = addr;
        core_req.wdata = wdata;
        core_req_valid = 1'b1;
        core_rsp_ready = (hold == 0);
        n = 0;
        while (!core_req_ready) begin
            @(posedge inst_selfdefine);
            #1;
            n++;
            if (n > wait_limit) abort_run("timed out waiting for request accept");
        end
        @(posedge inst_selfdefine);
        #1;
        core_req_valid = 1'b0;
        n = 0;
        while (!core_rsp_valid) begin
            @(posedge inst_selfdefine);
            #1;
            n++;
            if (n > wait_limit) abort_run("timed out waiting for response");
        end
        rdata = core_rsp.rdata;
        repeat (hold) begin
            @(posedge inst_selfdefine);
            #1;
        end
        core_rsp_ready = 1'b1;
        @(posedge inst_selfdefine);
        #1;
    endtask

    initial begin
        seed           = 66432;
        reset          = 1'b1;
        core_req_valid = 1'b0;
        core_req       = '0;
        core_rsp_ready = 1'b1;
        repeat (5) @(posedge inst_selfdefine);
        #1;
        reset = 1'b0;
        @(posedge inst_selfdefine);
        #1;
        for (int i = 0; i < 4; i++) begin
            repeat (4) do_access(ls_op_e'(7 + i), rand_addr(i),
                                 {32'($random(seed)), 32'($random(seed))}, 0, rd);
        end
        // clint address must not reach the external port
        do_access(store_word, clint_base + 64'h100, 64'h1234, 0, rd);
        for (int i = 0; i < 7; i++) begin
            repeat (4) do_access(ls_op_e'(i), rand_addr(i < 4 ? i : i - 4), '0, 0, rd);
        end
        do_access(load_half, rand_addr(0) | 64'd1, '0, 0, rd);
        do_access(store_word, rand_addr(2) | 64'd2, 64'hff, 0, rd);
        do_access(load_double, rand_addr(3) | 64'd4, '0, 0, rd);
        do_access(load_double, clint_base + mtime_offset, '0, 0, t0);
        do_access(store_double, clint_base + mtimecmp_offset, t0 + 64'd40, 0, rd);
        polls = 0;
        while (!mtip) begin
            do_access(load_double, clint_base + mtime_offset, '0, 0, rd);
            polls++;
            if (polls > 50) abort_run("timed out waiting for timer interrupt");
        end
        do_access(load_double, clint_base + mtime_offset, '0, 0, rd);
        do_access(load_word_u, rand_addr(2), '0, 4, rd);
        do_access(store_double, rand_addr(3), 64'h55aa, 3, rd);
        repeat (3) @(posedge inst_selfdefine);
        #1;
        if (u_dut.u_sva.fail_cnt != 0) begin
            abort_run("assertion failed");
        end else begin
            $display("All tests passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- verification/mem_subsys_sva.sv
`default_nettype none

module mem_subsys_sva #(
    parameter lsu_pkg::addr_t clint_base = 64'h0000_0000_0200_0000
) (
    input logic               inst_selfdefine,
    input logic               reset,
    input logic               core_req_valid,
    input logic               core_req_ready,
    input lsu_pkg::core_req_t core_req,
    input logic               core_rsp_valid,
    input logic               core_rsp_ready,
    input lsu_pkg::core_rsp_t core_rsp,
    input logic               ext_valid,
    input logic               ext_ready,
    input lsu_pkg::bus_req_t  ext_req,
    input lsu_pkg::bus_rsp_t  ext_rsp,
    input logic               mtip
);
    timeunit 1ns;
    timeprecision 1ps;
    import lsu_pkg::*;

    int     fail_cnt = 0;
    ls_op_e op_q;
    addr_t  addr_q;
    xlen_t  wdata_q;
    xlen_t  cap_q;
    xlen_t  cmp_q;
    xlen_t  last_t;
    logic   have_t;
    logic   pending;
    logic   went_ext;
    logic   rsp_valid_q;
    logic   rsp_rise;
    logic   mtime_rd;

    // log2 of the access size in bytes
    function automatic int size_of(input ls_op_e op);
        case (op)
            load_byte, load_byte_u, store_byte: return 0;
            load_half, load_half_u, store_half: return 1;
            load_word, load_word_u, store_word: return 2;
            default:                            return 3;
        endcase
    endfunction

    function automatic logic is_store(input ls_op_e op);
        return op >= store_byte;
    endfunction

    function automatic logic misaligned(input ls_op_e op, input addr_t addr);
        return (addr & ((64'd1 << size_of(op)) - 64'd1)) != 64'd0;
    endfunction

    function automatic logic in_window(input addr_t addr);
        return (addr >= clint_base) && (addr < clint_base + clint_span);
    endfunction

    function automatic xlen_t expect_load(input ls_op_e op, input xlen_t word, input addr_t addr);
        xlen_t w;
        w = word >> (8 * addr[2:0]);
        case (op)
            load_byte:   return xlen_t'($signed(w[7:0]));
            load_half:   return xlen_t'($signed(w[15:0]));
            load_word:   return xlen_t'($signed(w[31:0]));
            load_byte_u: return xlen_t'(w[7:0]);
            load_half_u: return xlen_t'(w[15:0]);
            load_word_u: return xlen_t'(w[31:0]);
            default:     return w;
        endcase
    endfunction

    // first cycle of a response
    assign rsp_rise = core_rsp_valid && !rsp_valid_q;
    assign mtime_rd = rsp_rise && (op_q == load_double)
                      && (addr_q == clint_base + mtime_offset);

    always_ff @(posedge inst_selfdefine) begin
        if (reset) begin
            pending     <= 1'b0;
            went_ext    <= 1'b0;
            have_t      <= 1'b0;
            cmp_q       <= '1;
            rsp_valid_q <= 1'b0;
        end else begin
            rsp_valid_q <= core_rsp_valid;
            if (core_req_valid && core_req_ready) begin
                op_q     <= core_req.op;
                addr_q   <= core_req.addr;
                wdata_q  <= core_req.wdata;
                pending  <= 1'b1;
                went_ext <= 1'b0;
                if (core_req.op == store_double
                        && core_req.addr == clint_base + mtimecmp_offset) begin
                    cmp_q <= core_req.wdata;
                end
            end
            if (core_rsp_valid && core_rsp_ready) begin
                pending <= 1'b0;
            end
            if (ext_valid && ext_ready) begin
                went_ext <= 1'b1;
                cap_q    <= ext_rsp.rdata;
            end
            if (mtime_rd) begin
                have_t <= 1'b1;
                last_t <= core_rsp.rdata;
            end
        end
    end

    reset_state: assert property (@(posedge inst_selfdefine)
        $fell(reset) |-> !core_rsp_valid && !ext_valid && !mtip && core_req_ready)
        else begin fail_cnt++; $error("mismatch at %0t: state after reset", $time); end

    ext_request: assert property (@(posedge inst_selfdefine) disable iff (reset)
        ext_valid |-> ext_req.addr == addr_q && ext_req.write == is_store(op_q)
            && int'(ext_req.size) == size_of(op_q)
            && !in_window(addr_q) && !misaligned(op_q, addr_q))
        else begin fail_cnt++; $error("mismatch at %0t: ext request fields", $time); end

    store_lanes: assert property (@(posedge inst_selfdefine) disable iff (reset)
        ext_valid && ext_req.write |-> ext_req.wdata == (wdata_q << (8 * addr_q[2:0])))
        else begin fail_cnt++; $error("mismatch at %0t: store byte lanes", $time); end

    load_result: assert property (@(posedge inst_selfdefine) disable iff (reset)
        $rose(core_rsp_valid) && went_ext && !is_store(op_q)
            |-> core_rsp.rdata == expect_load(op_q, cap_q, addr_q)
                && core_rsp.resp == resp_okay)
        else begin fail_cnt++; $error("mismatch at %0t: load data", $time); end

    misaligned_err: assert property (@(posedge inst_selfdefine) disable iff (reset)
        $rose(core_rsp_valid) && misaligned(op_q, addr_q) |-> core_rsp.resp == resp_error)
        else begin fail_cnt++; $error("mismatch at %0t: misaligned response", $time); end

    mtime_rising: assert property (@(posedge inst_selfdefine) disable iff (reset)
        mtime_rd && have_t |-> core_rsp.rdata > last_t)
        else begin fail_cnt++; $error("mismatch at %0t: mtime not increasing", $time); end

    mtip_high: assert property (@(posedge inst_selfdefine) disable iff (reset)
        mtime_rd && core_rsp.rdata >= cmp_q |-> mtip)
        else begin fail_cnt++; $error("mismatch at %0t: mtip low", $time); end

    // two cycles of slack for the registered mtip
    mtip_low: assert property (@(posedge inst_selfdefine) disable iff (reset)
        mtime_rd && core_rsp.rdata + 64'd2 < cmp_q |-> !mtip)
        else begin fail_cnt++; $error("mismatch at %0t: mtip high", $time); end

    rsp_hold: assert property (@(posedge inst_selfdefine) disable iff (reset)
        core_rsp_valid && !core_rsp_ready |=> core_rsp_valid && $stable(core_rsp))
        else begin fail_cnt++; $error("mismatch at %0t: held response changed", $time); end

    req_blocked: assert property (@(posedge inst_selfdefine) disable iff (reset)
        pending |-> !core_req_ready)
        else begin fail_cnt++; $error("mismatch at %0t: request ready while busy", $time); end

endmodule

bind mem_subsys_top mem_subsys_sva #(.clint_base(clint_base)) u_sva (
    .inst_selfdefine (inst_selfdefine),
    .reset           (reset),
    .core_req_valid  (core_req_valid),
    .core_req_ready  (core_req_ready),
    .core_req        (core_req),
    .core_rsp_valid  (core_rsp_valid),
    .core_rsp_ready  (core_rsp_ready),
    .core_rsp        (core_rsp),
    .ext_valid       (ext_valid),
    .ext_ready       (ext_ready),
    .ext_req         (ext_req),
    .ext_rsp         (ext_rsp),
    .mtip            (mtip)
);

`default_nettype wire

//--- verification/ext_mem_model.sv
`default_nettype none

module ext_mem_model (
    input  logic              inst_selfdefine,
    input  logic              reset,
    input  logic              ext_valid,
    output logic              ext_ready,
    input  lsu_pkg::bus_req_t ext_req,
    output lsu_pkg::bus_rsp_t ext_rsp
);
    timeunit 1ns;
    timeprecision 1ps;
    import lsu_pkg::*;

    integer     seed;
    logic [1:0] wait_cnt;
    logic       reset_seen;
    logic       valid_seen;

    initial begin
        seed      = 66432;
        ext_ready = 1'b0;
        ext_rsp   = '0;
        wait_cnt  = 2'd1;
    end

    // random read data and a random 0..3 cycle ready delay
    // decided on the edge, driven just after it
    always @(posedge inst_selfdefine) begin
        reset_seen = reset;
        valid_seen = ext_valid;
        #1;
        if (reset_seen) begin
            ext_ready    = 1'b0;
            wait_cnt     = 2'd1;
            ext_rsp.resp = resp_okay;
        end else if (ext_ready) begin
            ext_ready = 1'b0;
            wait_cnt  = 2'($random(seed));
        end else if (valid_seen) begin
            if (wait_cnt == 2'd0) begin
                ext_ready     = 1'b1;
                ext_rsp.rdata = {32'($random(seed)), 32'($random(seed))};
                ext_rsp.resp  = resp_okay;
            end else begin
                wait_cnt = wait_cnt - 2'd1;
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/mem_subsys_top.sv
`default_nettype none

module mem_subsys_top #(
    parameter lsu_pkg::addr_t clint_base = 64'h0000_0000_0200_0000,
    parameter int unsigned    mtime_div  = 1
) (
    input  logic               inst_selfdefine,
    input  logic               reset,
    input  logic               core_req_valid,
    output logic               core_req_ready,
    input  lsu_pkg::core_req_t core_req,
    output logic               core_rsp_valid,
    input  logic               core_rsp_ready,
    output lsu_pkg::core_rsp_t core_rsp,
    output logic               ext_valid,
    input  logic               ext_ready,
    output lsu_pkg::bus_req_t  ext_req,
    input  lsu_pkg::bus_rsp_t  ext_rsp,
    output logic               mtip
);
    import lsu_pkg::*;

    logic     bus_valid;
    logic     bus_ready;
    bus_req_t bus_req;
    bus_rsp_t bus_rsp;
    logic     clint_valid;
    logic     clint_ready;
    bus_req_t clint_req;
    bus_rsp_t clint_rsp;

    load_store_unit u_lsu (
        .inst_selfdefine (inst_selfdefine),
        .reset           (reset),
        .core_req_valid  (core_req_valid),
        .core_req_ready  (core_req_ready),
        .core_req        (core_req),
        .core_rsp_valid  (core_rsp_valid),
        .core_rsp_ready  (core_rsp_ready),
        .core_rsp        (core_rsp),
        .bus_valid       (bus_valid),
        .bus_ready       (bus_ready),
        .bus_req         (bus_req),
        .bus_rsp         (bus_rsp)
    );

    mem_router #(
        .clint_base (clint_base)
    ) u_router (
        .bus_valid   (bus_valid),
        .bus_ready   (bus_ready),
        .bus_req     (bus_req),
        .bus_rsp     (bus_rsp),
        .clint_valid (clint_valid),
        .clint_ready (clint_ready),
        .clint_req   (clint_req),
        .clint_rsp   (clint_rsp),
        .ext_valid   (ext_valid),
        .ext_ready   (ext_ready),
        .ext_req     (ext_req),
        .ext_rsp     (ext_rsp)
    );

    clint_timer #(
        .mtime_div (mtime_div)
    ) u_clint (
        .inst_selfdefine (inst_selfdefine),
        .reset           (reset),
        .clint_valid     (clint_valid),
        .clint_ready     (clint_ready),
        .clint_req       (clint_req),
        .clint_rsp       (clint_rsp),
        .mtip            (mtip)
    );

endmodule

`default_nettype wire

//--- hw/mem_router.sv
`default_nettype none

module mem_router #(
    parameter lsu_pkg::addr_t clint_base = 64'h0000_0000_0200_0000
) (
    input  logic              bus_valid,
    output logic              bus_ready,
    input  lsu_pkg::bus_req_t bus_req,
    output lsu_pkg::bus_rsp_t bus_rsp,
    output logic              clint_valid,
    input  logic              clint_ready,
    output lsu_pkg::bus_req_t clint_req,
    input  lsu_pkg::bus_rsp_t clint_rsp,
    output logic              ext_valid,
    input  logic              ext_ready,
    output lsu_pkg::bus_req_t ext_req,
    input  lsu_pkg::bus_rsp_t ext_rsp
);
    import lsu_pkg::*;

    addr_t clint_offset;
    logic  in_clint;

    // addresses below the base wrap to a huge offset and miss the window
    assign clint_offset = bus_req.addr - clint_base;
    assign in_clint     = (clint_offset < clint_span);

    // exactly one target sees valid
    assign clint_valid = bus_valid && in_clint;
    assign ext_valid   = bus_valid && !in_clint;

    // clint decodes on the window offset
    always_comb begin
        clint_req      = bus_req;
        clint_req.addr = clint_offset;
    end

    assign ext_req = bus_req;

    always_comb begin
        if (in_clint) begin
            bus_ready = clint_ready;
            bus_rsp   = clint_rsp;
        end else begin
            bus_ready = ext_ready;
            bus_rsp   = ext_rsp;
        end
    end

endmodule

`default_nettype wire

//--- hw/clint_timer.sv
`default_nettype none

module clint_timer #(
    parameter int unsigned mtime_div = 1
) (
    input  logic              inst_selfdefine,
    input  logic              reset,
    input  logic              clint_valid,
    output logic              clint_ready,
    input  lsu_pkg::bus_req_t clint_req,
    output lsu_pkg::bus_rsp_t clint_rsp,
    output logic              mtip
);
    import lsu_pkg::*;

    xlen_t       mtime;
    xlen_t       mtimecmp;
    logic [31:0] div_cnt;
    logic        tick;
    logic        new_req;
    logic        hit_mtime;
    logic        hit_mtimecmp;
    logic        legal;
    logic        wr_mtime;
    logic        wr_mtimecmp;

    assign tick = (div_cnt == mtime_div - 1);

    // ready follows the first cycle of valid, then drops for one cycle
    assign new_req = clint_valid && !clint_ready;

    assign hit_mtime    = (clint_req.addr == mtime_offset);
    assign hit_mtimecmp = (clint_req.addr == mtimecmp_offset);
    // only doubleword accesses to the two registers
    assign legal        = (clint_req.size == size_double) && (hit_mtime || hit_mtimecmp);
    assign wr_mtime     = new_req && legal && clint_req.write && hit_mtime;
    assign wr_mtimecmp  = new_req && legal && clint_req.write && hit_mtimecmp;

    always_ff @(posedge inst_selfdefine) begin
        if (reset) begin
            div_cnt     <= '0;
            mtime       <= '0;
            mtimecmp    <= '1;
            mtip        <= 1'b0;
            clint_ready <= 1'b0;
        end else begin
            clint_ready <= new_req;
            mtip        <= (mtime >= mtimecmp);
            if (tick) begin
                div_cnt <= '0;
            end else begin
                div_cnt <= div_cnt + 32'd1;
            end
            // a bus write to mtime wins over the tick
            if (wr_mtime) begin
                mtime <= clint_req.wdata;
            end else if (tick) begin
                mtime <= mtime + 64'd1;
            end
            if (wr_mtimecmp) begin
                mtimecmp <= clint_req.wdata;
            end
        end
    end

    always_ff @(posedge inst_selfdefine) begin
        if (new_req) begin
            clint_rsp.resp <= legal ? resp_okay : resp_error;
            if (legal && !clint_req.write) begin
                clint_rsp.rdata <= hit_mtime ? mtime : mtimecmp;
            end else begin
                clint_rsp.rdata <= '0;
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/load_store_unit.sv
`default_nettype none

module load_store_unit (
    input  logic               inst_selfdefine,
    input  logic               reset,
    input  logic               core_req_valid,
    output logic               core_req_ready,
    input  lsu_pkg::core_req_t core_req,
    output logic               core_rsp_valid,
    input  logic               core_rsp_ready,
    output lsu_pkg::core_rsp_t core_rsp,
    output logic               bus_valid,
    input  logic               bus_ready,
    output lsu_pkg::bus_req_t  bus_req,
    input  lsu_pkg::bus_rsp_t  bus_rsp
);
    import lsu_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_bus,
        st_resp
    } state_e;

    state_e    state;
    ls_op_e    op_q;
    addr_t     addr_q;
    xlen_t     wdata_q;
    core_rsp_t rsp_q;
    xlen_t     rdata_shifted;
    xlen_t     load_data;
    logic      aligned;
    logic      accept;

    function automatic size_e op_size(input ls_op_e op);
        case (op)
            load_byte, load_byte_u, store_byte: return size_byte;
            load_half, load_half_u, store_half: return size_half;
            load_word, load_word_u, store_word: return size_word;
            default:                            return size_double;
        endcase
    endfunction

    function automatic logic op_is_store(input ls_op_e op);
        return op inside {store_byte, store_half, store_word, store_double};
    endfunction

    assign core_req_ready = (state == st_idle);
    assign core_rsp_valid = (state == st_resp);
    assign bus_valid      = (state == st_bus);
    assign accept         = core_req_valid && core_req_ready;
    assign core_rsp       = rsp_q;

    // address must be a multiple of the access size
    always_comb begin
        case (op_size(core_req.op))
            size_half:   aligned = (core_req.addr[0] == 1'b0);
            size_word:   aligned = (core_req.addr[1:0] == 2'b00);
            size_double: aligned = (core_req.addr[2:0] == 3'b000);
            default:     aligned = 1'b1;
        endcase
    end

    always_comb begin
        bus_req.addr  = addr_q;
        bus_req.wdata = wdata_q;
        bus_req.size  = op_size(op_q);
        bus_req.write = op_is_store(op_q);
    end

    // move the addressed bytes down to bit 0, then extend
    assign rdata_shifted = bus_rsp.rdata >> {addr_q[2:0], 3'b000};

    always_comb begin
        case (op_q)
            load_byte:   load_data = {{56{rdata_shifted[7]}}, rdata_shifted[7:0]};
            load_half:   load_data = {{48{rdata_shifted[15]}}, rdata_shifted[15:0]};
            load_word:   load_data = {{32{rdata_shifted[31]}}, rdata_shifted[31:0]};
            load_double: load_data = rdata_shifted;
            load_byte_u: load_data = {56'd0, rdata_shifted[7:0]};
            load_half_u: load_data = {48'd0, rdata_shifted[15:0]};
            load_word_u: load_data = {32'd0, rdata_shifted[31:0]};
            default:     load_data = '0;
        endcase
    end

    always_ff @(posedge inst_selfdefine) begin
        if (reset) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle: begin
                    if (accept) begin
                        state <= aligned ? st_bus : st_resp;
                    end
                end
                st_bus: begin
                    if (bus_ready) begin
                        state <= st_resp;
                    end
                end
                st_resp: begin
                    if (core_rsp_ready) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // misaligned accesses keep the error loaded at acceptance
    always_ff @(posedge inst_selfdefine) begin
        if (accept) begin
            op_q        <= core_req.op;
            addr_q      <= core_req.addr;
            wdata_q     <= core_req.wdata << {core_req.addr[2:0], 3'b000};
            rsp_q.rdata <= '0;
            rsp_q.resp  <= resp_error;
        end else if (bus_valid && bus_ready) begin
            rsp_q.rdata <= load_data;
            rsp_q.resp  <= bus_rsp.resp;
        end
    end

endmodule

`default_nettype wire

//--- hw/lsu_pkg.sv
`default_nettype none

package lsu_pkg;

    typedef logic [63:0] xlen_t;
    typedef logic [63:0] addr_t;

    // one code per load/store flavour
    typedef enum logic [3:0] {
        load_byte    = 4'd0,
        load_half    = 4'd1,
        load_word    = 4'd2,
        load_double  = 4'd3,
        load_byte_u  = 4'd4,
        load_half_u  = 4'd5,
        load_word_u  = 4'd6,
        store_byte   = 4'd7,
        store_half   = 4'd8,
        store_word   = 4'd9,
        store_double = 4'd10
    } ls_op_e;

    typedef enum logic [1:0] {
        size_byte   = 2'd0,
        size_half   = 2'd1,
        size_word   = 2'd2,
        size_double = 2'd3
    } size_e;

    typedef enum logic [1:0] {
        resp_okay  = 2'd0,
        resp_error = 2'd2
    } resp_e;

    typedef struct packed {
        ls_op_e op;
        addr_t  addr;
        xlen_t  wdata;
    } core_req_t;

    typedef struct packed {
        xlen_t rdata;
        resp_e resp;
    } core_rsp_t;

    // wdata already sits in its byte lanes
    typedef struct packed {
        addr_t addr;
        xlen_t wdata;
        size_e size;
        logic  write;
    } bus_req_t;

    typedef struct packed {
        xlen_t rdata;
        resp_e resp;
    } bus_rsp_t;

    // clint register map, offsets within the window
    localparam addr_t mtimecmp_offset = 64'h0000_0000_0000_4000;
    localparam addr_t mtime_offset    = 64'h0000_0000_0000_bff8;
    localparam addr_t clint_span      = 64'h0000_0000_0001_0000;

endpackage

`default_nettype wire
